//--- ex_alu.sv
//////////////////////////////////////////////////
// Integer ALU with shared adder and shifter, also
// provides the branch compare for the stage
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_alu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_en_i,
  input  ex_pkg::alu_req_t alu_req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  // Reverse bit order, lets one right shifter serve SLL
  function automatic ex_pkg::word_t bit_rev(input ex_pkg::word_t v);
    ex_pkg::word_t r;
    int            i;
    for (i = 0; i < ex_pkg::XLEN; i++) begin
      r[i] = v[ex_pkg::XLEN-1-i];
    end
    return r;
  endfunction

  ex_pkg::word_t         op_a;
  ex_pkg::word_t         op_b;
  logic                  is_sub;
  ex_pkg::word_t         adder_b;
  logic                  carry;
  ex_pkg::word_t         sum;
  logic                  lt_s;
  logic                  lt_u;
  logic                  eq;
  logic                  shift_left;
  logic                  shift_arith;
  ex_pkg::word_t         shift_src;
  logic [ex_pkg::XLEN:0] shift_wide;
  ex_pkg::word_t         shift_res;

  assign op_a = alu_req_i.a;
  assign op_b = alu_req_i.b;

  //////////////////////////////////////////////////
  // Adder, subtract for SUB and every compare
  //////////////////////////////////////////////////
  assign is_sub  = (alu_req_i.op != ex_pkg::ADD);
  assign adder_b = is_sub ? ~op_b : op_b;
  assign {carry, sum} = {1'b0, op_a} + {1'b0, adder_b} + {{ex_pkg::XLEN{1'b0}}, is_sub};

  // No borrow means a >= b unsigned
  assign lt_u = ~carry;
  // Differing signs decide directly, else the difference sign
  assign lt_s = (op_a[ex_pkg::XLEN-1] != op_b[ex_pkg::XLEN-1]) ?
                op_a[ex_pkg::XLEN-1] : sum[ex_pkg::XLEN-1];
  assign eq   = (op_a == op_b);

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////
  assign shift_left  = (alu_req_i.op == ex_pkg::SLL);
  assign shift_arith = (alu_req_i.op == ex_pkg::SRA);
  assign shift_src   = shift_left ? bit_rev(op_a) : op_a;
  // Extra top bit is the fill, sign only for SRA
  assign shift_wide  = $signed({shift_arith & shift_src[ex_pkg::XLEN-1], shift_src})
                       >>> op_b[4:0];
  assign shift_res   = shift_left ? bit_rev(shift_wide[ex_pkg::XLEN-1:0])
                                  : shift_wide[ex_pkg::XLEN-1:0];

  // One comparator for set-less-than and branches
  always_comb begin
    case (alu_req_i.op)
      ex_pkg::EQ:                cmp_result_o = eq;
      ex_pkg::NE:                cmp_result_o = ~eq;
      ex_pkg::SLT,  ex_pkg::LT:  cmp_result_o = lt_s;
      ex_pkg::GE:                cmp_result_o = ~lt_s;
      ex_pkg::SLTU, ex_pkg::LTU: cmp_result_o = lt_u;
      ex_pkg::GEU:               cmp_result_o = ~lt_u;
      default:                   cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ADD, ex_pkg::SUB:              result_o = sum;
      ex_pkg::AND:                           result_o = op_a & op_b;
      ex_pkg::OR:                            result_o = op_a | op_b;
      ex_pkg::XOR:                           result_o = op_a ^ op_b;
      ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA: result_o = shift_res;
      // Compares return the flag in bit 0
      default: result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

  // ID never issues an encoding outside the opcode set
  a_legal_op: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_i |-> alu_req_i.op inside {ex_pkg::ADD, ex_pkg::SUB, ex_pkg::AND, ex_pkg::OR,
      ex_pkg::XOR, ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA, ex_pkg::SLT, ex_pkg::SLTU,
      ex_pkg::EQ, ex_pkg::NE, ex_pkg::LT, ex_pkg::GE, ex_pkg::LTU, ex_pkg::GEU});

endmodule

//--- ex_fw_mux.sv
//////////////////////////////////////////////////
// Forwarding write port select and the ready and
// valid handshake toward ID and WB
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_fw_mux (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  output ex_pkg::rf_wr_t    alu_fw_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic units_ready;

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  // Later assignment wins, so CSR beats MULT beats ALU
  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    alu_fw_o.wdata = '0;
    if (alu_en_i)     alu_fw_o.wdata = alu_result_i;
    if (mult_en_i)    alu_fw_o.wdata = mult_result_i;
    if (csr_access_i) alu_fw_o.wdata = csr_rdata_i;
  end

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////
  // ALU has no busy state, only MULT, LSU and WB can hold the stage
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here without needing WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid moves right, so it never waits on ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // ID decodes to one functional unit per instruction
  a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_en_i && mult_en_i));

endmodule

//--- ex_mult.sv
//////////////////////////////////////////////////
// Integer multiplier, MUL in one cycle and the
// upper-word ops over a four-state sequence
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mult_en_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              multicycle_o,
  output logic              ready_o
);

  ex_pkg::mult_state_e          state_q, state_d;
  logic                         high_req;
  logic                         a_signed, b_signed;
  logic [ex_pkg::XLEN:0]        a_ext, b_ext;
  logic signed [ex_pkg::HALF_W:0] pp_a, pp_b;
  logic signed [ex_pkg::XLEN+1:0] pp;
  logic [5:0]                   pp_shamt;
  logic [2*ex_pkg::XLEN-1:0]    pp_shifted;
  logic [2*ex_pkg::XLEN-1:0]    acc_q, acc_d, acc_sum;
  logic                         acc_en;
  ex_pkg::word_t                prod_lo;

  assign high_req = mult_en_i & (mult_req_i.op != ex_pkg::MUL);

  // Low word straight from a full multiply
  assign prod_lo = mult_req_i.a * mult_req_i.b;

  //////////////////////////////////////////////////
  // Partial products for the upper word
  //////////////////////////////////////////////////
  assign a_signed = (mult_req_i.op == ex_pkg::MULH) | (mult_req_i.op == ex_pkg::MULHSU);
  assign b_signed = (mult_req_i.op == ex_pkg::MULH);
  // 33-bit operands so the unsigned cases fit the signed array
  assign a_ext = {a_signed & mult_req_i.a[ex_pkg::XLEN-1], mult_req_i.a};
  assign b_ext = {b_signed & mult_req_i.b[ex_pkg::XLEN-1], mult_req_i.b};

  // Operand halves per state with the low halves zero extended
  always_comb begin
    pp_a     = {1'b0, a_ext[ex_pkg::HALF_W-1:0]};
    pp_b     = {1'b0, b_ext[ex_pkg::HALF_W-1:0]};
    pp_shamt = 6'd0;
    case (state_q)
      ex_pkg::STEP0: begin
        pp_b     = b_ext[ex_pkg::XLEN:ex_pkg::HALF_W];
        pp_shamt = 6'(ex_pkg::HALF_W);
      end
      ex_pkg::STEP1: begin
        pp_a     = a_ext[ex_pkg::XLEN:ex_pkg::HALF_W];
        pp_shamt = 6'(ex_pkg::HALF_W);
      end
      ex_pkg::FINISH: begin
        pp_a     = a_ext[ex_pkg::XLEN:ex_pkg::HALF_W];
        pp_b     = b_ext[ex_pkg::XLEN:ex_pkg::HALF_W];
        pp_shamt = 6'(ex_pkg::XLEN);
      end
      default: ;
    endcase
  end

  // One shared 17x17 signed multiplier
  assign pp         = pp_a * pp_b;
  assign pp_shifted = {{(ex_pkg::XLEN-2){pp[ex_pkg::XLEN+1]}}, pp} << pp_shamt;
  // Accumulation wraps mod 2^64, which keeps the upper word exact
  assign acc_sum    = acc_q + pp_shifted;
  assign acc_d      = (state_q == ex_pkg::IDLE) ? pp_shifted : acc_sum;
  assign acc_en     = ((state_q == ex_pkg::IDLE) & high_req) |
                      (state_q == ex_pkg::STEP0) | (state_q == ex_pkg::STEP1);

  always_ff @(posedge clk) begin
    if (acc_en) begin
      acc_q <= acc_d;
    end
  end

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    ready_o = 1'b0;
    case (state_q)
      ex_pkg::IDLE: begin
        ready_o = ~high_req;
        if (high_req) state_d = ex_pkg::STEP0;
      end
      ex_pkg::STEP0:  state_d = ex_pkg::STEP1;
      ex_pkg::STEP1:  state_d = ex_pkg::FINISH;
      ex_pkg::FINISH: begin
        ready_o = 1'b1;
        // Hold the result while the stage is back-pressured
        if (ex_ready_i) state_d = ex_pkg::IDLE;
      end
      default: state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign multicycle_o = (state_q != ex_pkg::IDLE);
  // Upper word only valid in FINISH, low word otherwise
  assign result_o = (state_q == ex_pkg::FINISH) ? acc_sum[2*ex_pkg::XLEN-1:ex_pkg::XLEN]
                                                : prod_lo;

  // Upper word stays put until the stage accepts it
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::FINISH && !ex_ready_i) |=> $stable(result_o));

  // Stage stalls two cycles past the issue edge, then completes
  a_high_seq: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::IDLE && high_req) |=> !ready_o ##1 !ready_o ##1 ready_o);

endmodule

//--- ex_pkg.sv
//////////////////////////////////////////////////
// Shared widths, opcode enums and bus structs for
// the execute stage and its testbench
//////////////////////////////////////////////////

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data word
  localparam int XLEN       = 32;
  // Half word, used by the high-product sequencer
  localparam int HALF_W     = XLEN / 2;
  // Register file address, 64 entries
  localparam int REG_ADDR_W = 6;
  localparam int ALU_OP_W   = 5;
  localparam int MULT_OP_W  = 2;
  // Multiplier sequencer state
  localparam int MULT_ST_W  = 2;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////

  // Arithmetic, logic, shifts, set-less-than, then branch compares
  typedef enum logic [ALU_OP_W-1:0] {
    ADD, SUB,
    AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // MUL is single cycle, the rest return the upper word
  typedef enum logic [MULT_OP_W-1:0] {
    MUL, MULH, MULHSU, MULHU
  } mult_op_e;

  // High-product sequence, one partial product per state
  typedef enum logic [MULT_ST_W-1:0] {
    IDLE, STEP0, STEP1, FINISH
  } mult_state_e;

  //////////////////////////////////////////////////
  // Buses
  //////////////////////////////////////////////////

  // ALU request from ID, operand c carries the jump target
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  // Multiplier request from ID
  typedef struct packed {
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

endpackage

//--- ex_stage.sv
//////////////////////////////////////////////////
// Execute stage top, connects ALU, multiplier,
// write port select and the EX/WB register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU and multiplier requests from ID
  input  logic              alu_en_i,
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              mult_en_i,
  input  ex_pkg::mult_req_t mult_req_i,
  // CSR access
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // LSU
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // Destination info from ID
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,
  // Write ports
  output ex_pkg::rf_wr_t    alu_fw_o,
  output ex_pkg::rf_wr_t    wb_o,
  // Toward IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  // Status and handshake
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t alu_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  // Branch target is operand c, compare decides taken
  assign jump_target_o = alu_req_i.c;

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////
  ex_alu u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_en_i     (alu_en_i),
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Sequencer leaves FINISH only when the stage moves on
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_en_i    (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_fw_mux u_fw_mux (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .alu_fw_o            (alu_fw_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

  ex_wb_reg u_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_err_i       (lsu_err_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .wb_o            (wb_o)
  );

endmodule

//--- ex_wb_reg.sv
//////////////////////////////////////////////////
// EX/WB register for the load write-back port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_wb_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              lsu_err_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  output ex_pkg::rf_wr_t    wb_o
);

  logic              we_d;
  logic              we_q;
  ex_pkg::reg_addr_t waddr_q;

  // Faulting load never writes the register file
  assign we_d = regfile_we_i & ~lsu_err_i;

  // Write enable, valid implies WB ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= we_d;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      we_q <= 1'b0;
    end
  end

  // Address only follows real writes
  always_ff @(posedge clk) begin
    if (ex_valid_i && we_d) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives in WB, so it bypasses the register
  assign wb_o.we    = we_q;
  assign wb_o.waddr = waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_ex_stage \
  -Mdir obj_dir -o sim_ex_stage > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_ex_stage > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0

//--- tb_ex_stage.sv
//////////////////////////////////////////////////
// Self-checking testbench for the execute stage,
// LFSR stimulus checked against a cycle model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ex_stage;

  // Ops per random test, high multiplies take four cycles each
  localparam int N_OPS      = 300;
  localparam int N_HIGH     = 60;
  localparam int MAX_CYCLES = 2 * (5 * N_OPS + 4 * N_HIGH + 10);

  logic              clk;
  logic              rst_n;
  logic              alu_en;
  ex_pkg::alu_req_t  alu_req;
  logic              mult_en;
  ex_pkg::mult_req_t mult_req;
  logic              csr_access;
  ex_pkg::word_t     csr_rdata;
  logic              lsu_en;
  ex_pkg::word_t     lsu_rdata;
  logic              lsu_ready_ex;
  logic              lsu_err;
  logic              branch_in_ex;
  logic              regfile_alu_we;
  ex_pkg::reg_addr_t regfile_alu_waddr;
  logic              regfile_we;
  ex_pkg::reg_addr_t regfile_waddr;
  logic              wb_ready;
  ex_pkg::rf_wr_t    alu_fw;
  ex_pkg::rf_wr_t    wb;
  ex_pkg::word_t     jump_target;
  logic              branch_decision;
  logic              mult_multicycle;
  logic              ex_ready;
  logic              ex_valid;

  // Model state, mirrors the sequencer and the EX/WB register
  logic [31:0]         lfsr_q;
  ex_pkg::mult_state_e mdl_state;
  logic                mdl_we;
  ex_pkg::reg_addr_t   mdl_waddr;
  logic                mdl_addr_known;
  logic                seen_ready;
  int                  cycle_cnt = 0;

  ex_stage dut0 (
    .clk (clk), .rst_n (rst_n),
    .alu_en_i (alu_en), .alu_req_i (alu_req),
    .mult_en_i (mult_en), .mult_req_i (mult_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata),
    .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err),
    .branch_in_ex_i (branch_in_ex),
    .regfile_alu_we_i (regfile_alu_we), .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr),
    .wb_ready_i (wb_ready),
    .alu_fw_o (alu_fw), .wb_o (wb),
    .jump_target_o (jump_target), .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout, run exceeded %0d cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus source
  //////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit, bits shift in at the bottom
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[31]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic rand_bit();
    return 1'(take_bits(1));
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic cmp_model(input ex_pkg::alu_req_t r);
    case (r.op)
      ex_pkg::EQ:                return r.a == r.b;
      ex_pkg::NE:                return r.a != r.b;
      ex_pkg::SLT, ex_pkg::LT:   return $signed(r.a) < $signed(r.b);
      ex_pkg::GE:                return $signed(r.a) >= $signed(r.b);
      ex_pkg::SLTU, ex_pkg::LTU: return r.a < r.b;
      ex_pkg::GEU:               return r.a >= r.b;
      default:                   return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_req_t r);
    case (r.op)
      ex_pkg::ADD: return r.a + r.b;
      ex_pkg::SUB: return r.a - r.b;
      ex_pkg::AND: return r.a & r.b;
      ex_pkg::OR:  return r.a | r.b;
      ex_pkg::XOR: return r.a ^ r.b;
      ex_pkg::SLL: return r.a << r.b[4:0];
      ex_pkg::SRL: return r.a >> r.b[4:0];
      ex_pkg::SRA: return $signed(r.a) >>> r.b[4:0];
      // Set-less-than and compares give the flag in bit 0
      default:     return {{(ex_pkg::XLEN-1){1'b0}}, cmp_model(r)};
    endcase
  endfunction

  // Full 64-bit product, each operand extended by its own signedness
  function automatic logic [63:0] mult_model(input ex_pkg::mult_req_t r);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    a_ext = {32'b0, r.a};
    b_ext = {32'b0, r.b};
    if (r.op == ex_pkg::MULH || r.op == ex_pkg::MULHSU) a_ext[63:32] = {32{r.a[31]}};
    if (r.op == ex_pkg::MULH) b_ext[63:32] = {32{r.b[31]}};
    return a_ext * b_ext;
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input ex_pkg::word_t exp,
                            input ex_pkg::word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run("Data word mismatch");
    end
  endtask

  // Fields shown as we/waddr/wdata
  task automatic check_wr(input string name, input ex_pkg::rf_wr_t exp,
                          input ex_pkg::rf_wr_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b/%h/%h, got %b/%h/%h", $time, name,
               exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
      abort_run("Write port mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run("Control bit mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Cycle driver
  //////////////////////////////////////////////////
  // Called at the falling edge once inputs are set, returns at the next one
  task automatic run_cycle();
    logic           high_req;
    logic           mult_rdy;
    logic           units_rdy;
    logic           exp_ready;
    logic           exp_valid;
    logic [63:0]    prod;
    ex_pkg::rf_wr_t exp_fw;
    ex_pkg::rf_wr_t exp_wb;
    #2;
    high_req = mult_en && (mult_req.op != ex_pkg::MUL);
    case (mdl_state)
      ex_pkg::IDLE:   mult_rdy = !high_req;
      ex_pkg::FINISH: mult_rdy = 1'b1;
      default:        mult_rdy = 1'b0;
    endcase
    units_rdy = mult_rdy && lsu_ready_ex && wb_ready;
    exp_ready = units_rdy || branch_in_ex;
    exp_valid = (alu_en || mult_en || csr_access || lsu_en) && units_rdy;
    prod      = mult_model(mult_req);
    // CSR first, then multiplier, then ALU
    exp_fw.we    = regfile_alu_we;
    exp_fw.waddr = regfile_alu_waddr;
    if (csr_access) exp_fw.wdata = csr_rdata;
    else if (mult_en) exp_fw.wdata = (mdl_state == ex_pkg::FINISH) ? prod[63:32] : prod[31:0];
    else if (alu_en) exp_fw.wdata = alu_model(alu_req);
    else exp_fw.wdata = '0;
    check_bit("ex_ready_o", exp_ready, ex_ready);
    check_bit("ex_valid_o", exp_valid, ex_valid);
    check_bit("mult_multicycle_o", mdl_state != ex_pkg::IDLE, mult_multicycle);
    check_bit("branch_decision_o", cmp_model(alu_req), branch_decision);
    check_word("jump_target_o", alu_req.c, jump_target);
    check_wr("alu_fw_o", exp_fw, alu_fw);
    exp_wb = {mdl_we, mdl_waddr, lsu_rdata};
    if (mdl_addr_known) check_wr("wb_o", exp_wb, wb);
    else check_bit("wb_o.we", mdl_we, wb.we);
    seen_ready = ex_ready;
    @(posedge clk);
    case (mdl_state)
      ex_pkg::IDLE:   if (high_req) mdl_state = ex_pkg::STEP0;
      ex_pkg::STEP0:  mdl_state = ex_pkg::STEP1;
      ex_pkg::STEP1:  mdl_state = ex_pkg::FINISH;
      ex_pkg::FINISH: if (exp_ready) mdl_state = ex_pkg::IDLE;
      default:        mdl_state = ex_pkg::IDLE;
    endcase
    // Squashed load on a valid slot, flush when WB drains
    if (exp_valid) begin
      mdl_we = regfile_we && !lsu_err;
      if (mdl_we) begin
        mdl_waddr      = regfile_waddr;
        mdl_addr_known = 1'b1;
      end
    end else if (wb_ready) begin
      mdl_we = 1'b0;
    end
    @(negedge clk);
  endtask

  task automatic idle_inputs();
    alu_en            = 1'b0;
    alu_req           = '0;
    mult_en           = 1'b0;
    mult_req          = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    branch_in_ex      = 1'b0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    wb_ready          = 1'b1;
  endtask

  // Random data everywhere, no unit enabled, MUL only
  task automatic load_random_operands();
    idle_inputs();
    alu_req.op        = ex_pkg::alu_op_e'(5'(take_bits(4)));
    alu_req.a         = take_bits(32);
    alu_req.b         = take_bits(32);
    alu_req.c         = take_bits(32);
    mult_req.a        = take_bits(32);
    mult_req.b        = take_bits(32);
    csr_rdata         = take_bits(32);
    lsu_rdata         = take_bits(32);
    regfile_alu_we    = rand_bit();
    regfile_alu_waddr = 6'(take_bits(6));
    regfile_we        = rand_bit();
    regfile_waddr     = 6'(take_bits(6));
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_alu();
    for (int i = 0; i < N_OPS; i++) begin
      load_random_operands();
      alu_en = 1'b1;
      run_cycle();
    end
  endtask

  // Compare ops only, back-pressure must not hold a branch
  task automatic test_branch();
    for (int i = 0; i < N_OPS; i++) begin
      load_random_operands();
      alu_en       = 1'b1;
      branch_in_ex = 1'b1;
      alu_req.op   = ex_pkg::alu_op_e'(5'(ex_pkg::EQ) + 5'(take_bits(3) % 6));
      if (rand_bit()) alu_req.b = alu_req.a;
      lsu_ready_ex = rand_bit();
      wb_ready     = rand_bit();
      run_cycle();
    end
  endtask

  task automatic test_mul();
    for (int i = 0; i < N_OPS; i++) begin
      load_random_operands();
      mult_en = 1'b1;
      run_cycle();
    end
  endtask

  // ID holds the request through the stall
  task automatic test_mul_high();
    int stall;
    for (int i = 0; i < N_HIGH; i++) begin
      load_random_operands();
      mult_en     = 1'b1;
      mult_req.op = ex_pkg::mult_op_e'(2'(1 + take_bits(2) % 3));
      run_cycle();
      stall = 0;
      run_cycle();
      while (!seen_ready && stall < 8) begin
        stall++;
        run_cycle();
      end
      if (stall != 2) begin
        abort_run($sformatf("High multiply stalled %0d cycles after issue, 2 expected",
                            stall));
      end
    end
  endtask

  task automatic test_forward();
    logic [1:0] unit;
    for (int i = 0; i < N_OPS; i++) begin
      load_random_operands();
      unit         = 2'(take_bits(2));
      alu_en       = (unit == 2'd0) || (unit == 2'd3);
      mult_en      = (unit == 2'd1);
      csr_access   = rand_bit();
      lsu_en       = rand_bit();
      lsu_ready_ex = rand_bit();
      wb_ready     = rand_bit();
      run_cycle();
    end
  endtask

  // Loads with faults, sparse valid slots and WB stalls
  task automatic test_wb();
    for (int i = 0; i < N_OPS; i++) begin
      load_random_operands();
      lsu_en       = rand_bit();
      lsu_err      = rand_bit() & rand_bit();
      lsu_ready_ex = rand_bit() | rand_bit();
      wb_ready     = rand_bit() | rand_bit();
      run_cycle();
    end
  endtask

  initial begin
    lfsr_q         = 32'h5df5;
    mdl_state      = ex_pkg::IDLE;
    mdl_we         = 1'b0;
    mdl_waddr      = '0;
    mdl_addr_known = 1'b0;
    seen_ready     = 1'b0;
    rst_n          = 1'b0;
    idle_inputs();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_bit("wb_o.we", 1'b0, wb.we);
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle);
    @(negedge clk);
    test_alu();
    test_branch();
    test_mul();
    test_mul_high();
    test_forward();
    test_wb();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- verilog.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_fw_mux.sv
ex_wb_reg.sv
ex_stage.sv
tb_ex_stage.sv
